// File: Bender.yml
package:
  name: serdes_link

sources:
  - hdl/serdes_pkg.sv
  - hdl/link_regs.sv
  - hdl/pam4_tx.sv
  - hdl/isi_channel.sv
  - hdl/pam4_rx.sv
  - hdl/prbs_checker.sv
  - hdl/serdes_link_top.sv
  - target: simulation
    files:
      - tb/tb_serdes_link.sv

// File: all.f
hdl/serdes_pkg.sv
hdl/link_regs.sv
hdl/pam4_tx.sv
hdl/isi_channel.sv
hdl/pam4_rx.sv
hdl/prbs_checker.sv
hdl/serdes_link_top.sv
tb/tb_serdes_link.sv

// File: hdl/isi_channel.sv
`timescale 1ns/1ps

module isi_channel import serdes_pkg::*; (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   run,
    input  tap_t   post_tap,
    input  level_t tx_level,
    input  logic   tx_valid,
    output level_t ch_level,
    output logic   ch_valid
);

    localparam int PROD_W = $bits(level_t) + $bits(tap_t);
    localparam int ISI_W  = PROD_W - TAP_FRAC_BITS;  // product after the fraction shift

    level_t                   prev_level;  // previous symbol, post-cursor source
    logic signed [PROD_W-1:0] prod;
    logic signed [ISI_W-1:0]  isi;
    logic signed [ISI_W:0]    sum;
    level_t                   sat_level;

    assign prod = prev_level * post_tap;
    assign isi  = prod[PROD_W-1:TAP_FRAC_BITS];  // arithmetic shift by slicing
    assign sum  = tx_level + isi;

    // clip to the 8-bit range
    always_comb begin
        if (sum > 127) begin
            sat_level = 8'sd127;
        end else if (sum < -128) begin
            sat_level = -8'sd128;
        end else begin
            sat_level = level_t'(sum);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n || !run) begin
            prev_level <= '0;
            ch_valid   <= 1'b0;
        end else begin
            ch_valid <= tx_valid;
            if (tx_valid) prev_level <= tx_level;
        end
    end

    always_ff @(posedge clock) begin
        ch_level <= sat_level;  // payload, unreset
    end

endmodule

// File: hdl/link_regs.sv
`timescale 1ns/1ps

module link_regs import serdes_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    // axi4-lite write channels
    input  reg_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  count_t    wdata,
    input  logic      wvalid,
    output logic      wready,
    output logic [1:0] bresp,
    output logic      bvalid,
    input  logic      bready,
    // axi4-lite read channels
    input  reg_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output count_t    rdata,
    output logic [1:0] rresp,
    output logic      rvalid,
    input  logic      rready,
    // control to the data path
    output logic      run,
    output logic      dfe_en,
    output tap_t      post_tap,
    output logic      inject,
    // status from the checker
    input  count_t    bit_count,
    input  count_t    err_count
);

    localparam int PAD_W = $bits(count_t) - $bits(tap_t);  // sign-extension width

    logic wr_fire;   // aw and w taken together
    logic rd_fire;
    count_t rd_mux;

    assign wr_fire = awvalid && wvalid && !bvalid;  // pending response blocks writes
    assign rd_fire = arvalid && !rvalid;

    assign awready = !bvalid;
    assign wready  = !bvalid;
    assign arready = !rvalid;
    assign bresp   = 2'b00;  // always okay
    assign rresp   = 2'b00;

    // write side, control registers and the inject strobe
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            run      <= 1'b0;
            dfe_en   <= 1'b0;
            post_tap <= '0;
            inject   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            inject <= 1'b0;  // one cycle only
            if (wr_fire) begin
                bvalid <= 1'b1;
                case (awaddr)
                    REG_CTRL: begin
                        run    <= wdata[0];
                        dfe_en <= wdata[1];
                    end
                    REG_TAP:    post_tap <= tap_t'(wdata[$bits(tap_t)-1:0]);
                    REG_INJECT: inject   <= wdata[0];
                    default: ;  // counters and holes ignore writes
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read decode, live counters
    always_comb begin
        case (araddr)
            REG_CTRL: rd_mux = {{($bits(count_t) - 2){1'b0}}, dfe_en, run};
            REG_TAP:  rd_mux = {{PAD_W{post_tap[$bits(tap_t)-1]}}, post_tap};
            REG_BITS: rd_mux = bit_count;
            REG_ERRS: rd_mux = err_count;
            default:  rd_mux = '0;  // inject and unmapped read 0
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // data held with rvalid until rready
    always_ff @(posedge clock) begin
        if (rd_fire) begin
            rdata <= rd_mux;
        end
    end

endmodule

// File: hdl/pam4_rx.sv
`timescale 1ns/1ps

module pam4_rx import serdes_pkg::*; #(
    parameter int LEVEL_STEP = 24
) (
    input  logic    clock,
    input  logic    reset_n,
    input  logic    run,
    input  logic    dfe_en,
    input  tap_t    post_tap,
    input  level_t  ch_level,
    input  logic    ch_valid,
    output symbol_t rx_bits,   // first-sent bit in msb
    output logic    rx_valid
);

    localparam int PROD_W = $bits(level_t) + $bits(tap_t);
    localparam int ISI_W  = PROD_W - TAP_FRAC_BITS;
    localparam int THRESH = 2 * LEVEL_STEP;  // outer slicer thresholds

    level_t                   dec_prev;  // last decided level
    level_t                   dec_level;
    logic signed [PROD_W-1:0] prod;
    logic signed [ISI_W-1:0]  fb;
    logic signed [ISI_W:0]    eq_level;  // after feedback cancel
    symbol_t                  sym;

    assign prod     = dec_prev * post_tap;
    assign fb       = dfe_en ? prod[PROD_W-1:TAP_FRAC_BITS] : '0;
    assign eq_level = ch_level - fb;

    // three-threshold slicer, index 0..3
    always_comb begin
        if (eq_level >= THRESH) begin
            sym = 2'd3;
        end else if (eq_level >= 0) begin
            sym = 2'd2;
        end else if (eq_level >= -THRESH) begin
            sym = 2'd1;
        end else begin
            sym = 2'd0;
        end
    end

    assign dec_level = level_of(sym, LEVEL_STEP);  // ideal level for next feedback

    always_ff @(posedge clock) begin
        if (!reset_n || !run) begin
            dec_prev <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= ch_valid;
            if (ch_valid) dec_prev <= dec_level;
        end
    end

    // gray decode back to the bit pair
    always_ff @(posedge clock) begin
        rx_bits <= {sym[1], sym[1] ^ sym[0]};
    end

endmodule

// File: hdl/pam4_tx.sv
`timescale 1ns/1ps

module pam4_tx import serdes_pkg::*; #(
    parameter int LEVEL_STEP = 24  // half the level spacing
) (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   run,
    input  logic   inject,    // flips first bit of this symbol
    output level_t tx_level,
    output logic   tx_valid
);

    prbs_state_t lfsr;
    prbs_state_t lfsr_next;
    logic [1:0]  bit_pair;   // first bit in msb
    logic [1:0]  tx_pair;
    symbol_t     sym;

    assign lfsr_next = prbs_step2(lfsr);
    assign bit_pair  = lfsr_next[1:0];

    // error flip on the sent bit only, lfsr keeps the true sequence
    assign tx_pair = {bit_pair[1] ^ inject, bit_pair[0]};

    // gray code, 00 01 11 10 -> index 0..3
    assign sym = {tx_pair[1], tx_pair[1] ^ tx_pair[0]};

    always_ff @(posedge clock) begin
        if (!reset_n || !run) begin
            lfsr     <= PRBS_SEED;  // every run starts aligned
            tx_valid <= 1'b0;
        end else begin
            lfsr     <= lfsr_next;
            tx_valid <= 1'b1;       // one symbol per clock
        end
    end

    // level register, no reset
    always_ff @(posedge clock) begin
        if (run) begin
            tx_level <= level_of(sym, LEVEL_STEP);
        end
    end

endmodule

// File: hdl/prbs_checker.sv
`timescale 1ns/1ps

module prbs_checker import serdes_pkg::*; (
    input  logic    clock,
    input  logic    reset_n,
    input  logic    run,
    input  symbol_t rx_bits,
    input  logic    rx_valid,
    output count_t  bit_count,
    output count_t  err_count
);

    prbs_state_t ref_lfsr;  // local copy of the tx sequence
    prbs_state_t ref_next;
    logic [1:0]  diff;      // per-bit mismatch

    assign ref_next = prbs_step2(ref_lfsr);
    assign diff     = rx_bits ^ ref_next[1:0];

    always_ff @(posedge clock) begin
        if (!reset_n || !run) begin
            ref_lfsr  <= PRBS_SEED;
            bit_count <= '0;
            err_count <= '0;
        end else if (rx_valid) begin
            ref_lfsr  <= ref_next;          // two steps per symbol
            bit_count <= bit_count + count_t'(2);
            err_count <= err_count + count_t'(diff[1]) + count_t'(diff[0]);
        end
    end

endmodule

// File: hdl/serdes_link_top.sv
`timescale 1ns/1ps

module serdes_link_top import serdes_pkg::*; #(
    parameter int LEVEL_STEP = 24  // up to 31 fits level_t
) (
    input  logic       clock,
    input  logic       reset_n,
    input  reg_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  count_t     wdata,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    input  reg_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output count_t     rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready
);

    logic    run;
    logic    dfe_en;
    logic    inject;
    tap_t    post_tap;   // shared by channel and dfe
    level_t  tx_level;
    logic    tx_valid;
    level_t  ch_level;
    logic    ch_valid;
    symbol_t rx_bits;
    logic    rx_valid;
    count_t  bit_count;
    count_t  err_count;

    link_regs u_regs (
        .clock, .reset_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .run, .dfe_en, .post_tap, .inject, .bit_count, .err_count
    );

    pam4_tx #(.LEVEL_STEP(LEVEL_STEP)) u_tx (
        .clock, .reset_n, .run, .inject, .tx_level, .tx_valid
    );

    isi_channel u_channel (
        .clock, .reset_n, .run, .post_tap, .tx_level, .tx_valid, .ch_level, .ch_valid
    );

    pam4_rx #(.LEVEL_STEP(LEVEL_STEP)) u_rx (
        .clock, .reset_n, .run, .dfe_en, .post_tap, .ch_level, .ch_valid,
        .rx_bits, .rx_valid
    );

    prbs_checker u_checker (
        .clock, .reset_n, .run, .rx_bits, .rx_valid, .bit_count, .err_count
    );

endmodule

// File: hdl/serdes_pkg.sv
package serdes_pkg;

    typedef logic signed [7:0] level_t;   // line voltage, tx and rx side
    typedef logic signed [7:0] tap_t;     // post-cursor coefficient, fixed point
    typedef logic [1:0]        symbol_t;  // pam-4 symbol index after gray coding
    typedef logic [30:0]       prbs_state_t;
    typedef logic [31:0]       count_t;   // also the axi data width
    typedef logic [4:0]        reg_addr_t;

    localparam int TAP_FRAC_BITS = 6;     // tap of 64 is unity

    // common start state for tx and checker
    localparam prbs_state_t PRBS_SEED = 31'h68ad_251f;

    // register map, byte offsets
    localparam reg_addr_t REG_CTRL   = 5'h00;  // [0] run, [1] dfe_en
    localparam reg_addr_t REG_TAP    = 5'h04;  // signed tap, low byte
    localparam reg_addr_t REG_INJECT = 5'h08;  // write-one pulse
    localparam reg_addr_t REG_BITS   = 5'h0c;  // read only
    localparam reg_addr_t REG_ERRS   = 5'h10;  // read only

    // two steps of x^31 + x^28 + 1
    // new bits land in [1:0], first generated bit in [1]
    function automatic prbs_state_t prbs_step2(prbs_state_t s);
        logic b0;
        logic b1;
        b0 = s[30] ^ s[27];
        b1 = s[29] ^ s[26];  // same taps one step later
        return {s[28:0], b0, b1};
    endfunction

    // symbol index 0..3 to -3, -1, +1, +3 steps
    function automatic level_t level_of(symbol_t sym, int step);
        return level_t'((2 * int'(sym) - 3) * step);
    endfunction

endpackage

// File: tb/tb_serdes_link.sv
`timescale 1ns/1ps

module tb_serdes_link import serdes_pkg::*; ();

    localparam int        LEVEL_STEP = 24;
    localparam int        TIMEOUT    = 100;    // cycles allowed per handshake
    localparam reg_addr_t HOLE_A     = 5'h14;  // unmapped offsets
    localparam reg_addr_t HOLE_B     = 5'h1c;

    logic       clock;
    logic       reset_n;
    reg_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    count_t     wdata;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    reg_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    count_t     rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    integer seed;
    int     errors;
    int     checks;
    logic   exp_run;   // register model
    logic   exp_dfe;
    tap_t   exp_tap;

    serdes_link_top #(.LEVEL_STEP(LEVEL_STEP)) dut (
        .clock, .reset_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clock);
    endtask

    task automatic check_equal(input string name, input count_t expected, input count_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // full-word write, waits for aw/w then the b response
    task automatic axi_write(input reg_addr_t addr, input count_t data);
        int t;
        @(posedge clock);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        t = 0;
        @(negedge clock);  // readies are settled here
        while (!(awready && wready) && t < TIMEOUT) begin
            @(negedge clock);
            t++;
        end
        if (t >= TIMEOUT) begin
            errors++;
            $display("Write to address %0h was never accepted", addr);
        end
        @(posedge clock);  // handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        t = 0;
        @(negedge clock);
        while (!bvalid && t < TIMEOUT) begin
            @(negedge clock);
            t++;
        end
        if (t >= TIMEOUT) begin
            errors++;
            $display("No write response came for address %0h", addr);
        end else begin
            check_equal("bresp", 2'b00, bresp);
        end
        @(posedge clock);
        bready <= 1'b0;  // response taken on this edge
    endtask

    task automatic axi_read(input reg_addr_t addr, output count_t data);
        int t;
        @(posedge clock);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        t = 0;
        data = '0;
        @(negedge clock);
        while (!arready && t < TIMEOUT) begin
            @(negedge clock);
            t++;
        end
        if (t >= TIMEOUT) begin
            errors++;
            $display("Read of address %0h was never accepted", addr);
        end
        @(posedge clock);
        arvalid <= 1'b0;
        t = 0;
        @(negedge clock);
        while (!rvalid && t < TIMEOUT) begin
            @(negedge clock);
            t++;
        end
        if (t >= TIMEOUT) begin
            errors++;
            $display("No read data came for address %0h", addr);
        end else begin
            data = rdata;
            check_equal("rresp", 2'b00, rresp);
        end
        @(posedge clock);
        rready <= 1'b0;
    endtask

    initial begin
        count_t word;
        count_t rd;
        count_t b1;
        count_t b2;
        int     n;
        int     mag;
        tap_t   tap;
        seed    = 32'hb7f1_728e;
        errors  = 0;
        checks  = 0;
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        wait_cycles(4);
        reset_n <= 1'b1;
        @(negedge clock);
        check_equal("reset_ready", 3'b111, {awready, wready, arready});
        check_equal("reset_valid", 2'b00, {bvalid, rvalid});

        // register access, tap sign-extended on read
        for (int i = 0; i < 8; i++) begin
            word = $random(seed);
            axi_write(REG_TAP, word);
            exp_tap = word[7:0];
            axi_read(REG_TAP, rd);
            check_equal("reg_tap", {{24{exp_tap[7]}}, exp_tap}, rd);
            word = $random(seed);
            axi_write(REG_CTRL, word);
            exp_run = word[0];
            exp_dfe = word[1];
            axi_read(REG_CTRL, rd);
            check_equal("reg_ctrl", {30'b0, exp_dfe, exp_run}, rd);
        end
        axi_write(REG_INJECT, 32'h1);
        axi_read(REG_INJECT, rd);
        check_equal("reg_inject", 0, rd);
        axi_read(HOLE_A, rd);
        check_equal("hole_a", 0, rd);
        axi_read(HOLE_B, rd);
        check_equal("hole_b", 0, rd);

        // clean link, no isi
        axi_write(REG_CTRL, 32'h0);
        axi_write(REG_TAP, 32'h0);
        axi_write(REG_CTRL, 32'h1);
        wait_cycles(20 + $unsigned($random(seed)) % 64);
        axi_read(REG_BITS, b1);
        axi_read(REG_BITS, b2);
        check_equal("clean_even_1", 0, b1[0]);
        check_equal("clean_even_2", 0, b2[0]);
        checks++;
        if (b2 <= b1) begin
            errors++;
            $display("Mismatch clean_grow: expected more than %0d, actual %0d", b1, b2);
        end
        axi_read(REG_ERRS, rd);
        check_equal("clean_errs", 0, rd);

        // injected flips, one wrong bit each
        n = 1 + $unsigned($random(seed)) % 8;
        for (int i = 0; i < n; i++) begin
            axi_write(REG_INJECT, 32'h1);
            wait_cycles(8);
        end
        wait_cycles(10);  // drain the pipeline
        axi_read(REG_ERRS, rd);
        check_equal("inject_errs", n, rd);

        // strong post-cursor, first without the dfe
        mag = 36 + $unsigned($random(seed)) % 13;
        tap = ($random(seed) & 1) ? tap_t'(-mag) : tap_t'(mag);
        axi_write(REG_CTRL, 32'h0);
        axi_write(REG_TAP, {{24{tap[7]}}, tap});
        axi_write(REG_CTRL, 32'h1);
        wait_cycles(200);
        axi_read(REG_ERRS, rd);
        checks++;
        if (rd == 0) begin
            errors++;
            $display("Mismatch isi_errs: expected above 0, actual %0d (tap %0d)", rd, tap);
        end
        axi_write(REG_CTRL, 32'h0);
        axi_write(REG_CTRL, 32'h3);  // restart with dfe on
        wait_cycles(40 + $unsigned($random(seed)) % 64);
        axi_read(REG_BITS, b1);
        wait_cycles(50);
        axi_read(REG_BITS, b2);
        axi_read(REG_ERRS, rd);
        check_equal("dfe_errs", 0, rd);
        checks++;
        if (b2 <= b1) begin
            errors++;
            $display("Mismatch dfe_grow: expected more than %0d, actual %0d", b1, b2);
        end

        // stop clears the counters
        axi_write(REG_CTRL, 32'h0);
        wait_cycles(2);
        axi_read(REG_BITS, rd);
        check_equal("clear_bits", 0, rd);
        axi_read(REG_ERRS, rd);
        check_equal("clear_errs", 0, rd);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
